//--- Bender.yml
package:
  name: video_to_ram

sources:
  # RTL, package first
  - files:
      - design/vram_pkg.sv
      - design/line_buffer.sv
      - design/line_capture.sv
      - design/burst_writer.sv
      - design/video_to_ram.sv

  # Testbench and bound assertions
  - target: test
    files:
      - dv/video_to_ram_sva.sv
      - dv/tb_video_to_ram.sv

//--- design/burst_writer.sv
// Writes one ready line as 45 bursts of 16 words; burst length is implied, not sent
// Read data from the line buffer must arrive one cycle after o_rd_idx
`timescale 1ns/1ns

module burst_writer
(
	input  logic                i_clk_100_bus,
	input  logic                i_sys_rst,
	input  logic                i_mem_init_done,
	input  logic                i_line_ready,
	input  vram_pkg::t_line_num i_line_num,
	output logic                o_rd_en,
	output vram_pkg::t_buf_addr o_rd_idx,
	input  vram_pkg::t_rgb      i_rd_rgb,
	output logic                o_req,
	output vram_pkg::t_mem_addr o_addr,
	input  logic                i_addr_ack,
	output logic                o_wr_valid,
	output vram_pkg::t_mem_word o_wr_data,
	input  logic                i_wr_ready,
	output logic                o_line_complete
);

	vram_pkg::t_wr_state  r_cs;
	vram_pkg::t_wr_state  c_ns;
	vram_pkg::t_mem_addr  r_addr;		// Address of current burst
	vram_pkg::t_buf_addr  r_rd_idx;		// Next pixel to fetch
	vram_pkg::t_burst_cnt r_burst_cnt;	// Bursts acknowledged this line
	vram_pkg::t_beat_cnt  r_beat_cnt;	// Beats accepted this burst

	logic w_ack;		// Address handshake
	logic w_accept;		// Data beat transfers
	logic w_last_beat;
	logic w_line_end;

	assign w_ack       = (r_cs == vram_pkg::s_request) && i_addr_ack;
	assign w_accept    = (r_cs == vram_pkg::s_write) && i_wr_ready;
	assign w_last_beat = r_beat_cnt == vram_pkg::t_beat_cnt'(vram_pkg::BURST_LEN - 1);
	assign w_line_end  = (r_cs == vram_pkg::s_complete) &&
		(r_burst_cnt == vram_pkg::t_burst_cnt'(vram_pkg::BURSTS_PER_LINE));

	////////////////////
	// Next state
	////////////////////

	always_comb
	begin
		c_ns = r_cs;
		case (r_cs)
		vram_pkg::s_init:
		begin
			if (i_mem_init_done)
			begin
				c_ns = vram_pkg::s_start_line;
			end
		end
		vram_pkg::s_start_line:
		begin
			if (i_line_ready)
			begin
				c_ns = vram_pkg::s_request;
			end
		end
		vram_pkg::s_request:
		begin
			if (i_addr_ack)
			begin
				c_ns = vram_pkg::s_write;	// First word fetched on this edge
			end
		end
		vram_pkg::s_write:
		begin
			if (w_accept && w_last_beat)
			begin
				c_ns = vram_pkg::s_complete;
			end
		end
		vram_pkg::s_complete:
		begin
			if (w_line_end)
			begin
				c_ns = vram_pkg::s_start_line;
			end
			else
			begin
				c_ns = vram_pkg::s_request;
			end
		end
		default:
		begin
			c_ns = vram_pkg::s_init;
		end
		endcase
	end

	////////////////////
	// Registers
	////////////////////

	always_ff @(posedge i_clk_100_bus or posedge i_sys_rst)
	begin
		if (i_sys_rst)
		begin
			r_cs        <= vram_pkg::s_init;
			r_addr      <= vram_pkg::VIDEO_RAM_BASE;
			r_rd_idx    <= '0;
			r_burst_cnt <= '0;
			r_beat_cnt  <= '0;
		end
		else
		begin
			r_cs <= c_ns;

			// Line setup, reloaded every cycle while waiting
			if (r_cs == vram_pkg::s_start_line)
			begin
				r_addr <= vram_pkg::VIDEO_RAM_BASE +
					vram_pkg::t_mem_addr'(i_line_num) *
					vram_pkg::t_mem_addr'(vram_pkg::BYTES_PER_LINE);
				r_rd_idx    <= vram_pkg::t_buf_addr'(vram_pkg::LINE_OFFSET);
				r_burst_cnt <= '0;
			end
			else
			begin
				if (r_cs == vram_pkg::s_complete)
				begin
					r_addr <= r_addr + vram_pkg::t_mem_addr'(vram_pkg::BYTES_PER_BURST);
				end
				if (o_rd_en)
				begin
					r_rd_idx <= r_rd_idx + 1'b1;	// Stay one word ahead
				end
				if (w_ack)
				begin
					r_burst_cnt <= r_burst_cnt + 1'b1;
				end
			end

			// Beat count per burst
			if (w_ack)
			begin
				r_beat_cnt <= '0;
			end
			else if (w_accept)
			begin
				r_beat_cnt <= r_beat_cnt + 1'b1;
			end
		end
	end

	////////////////////
	// Outputs
	////////////////////

	// Fetch on ack, then on every accepted beat except the last of a burst
	// A stalled beat fetches nothing, so the buffer register holds its word
	assign o_rd_en  = w_ack || (w_accept && !w_last_beat);
	assign o_rd_idx = r_rd_idx;

	assign o_req      = (r_cs == vram_pkg::s_request);
	assign o_addr     = r_addr;
	assign o_wr_valid = (r_cs == vram_pkg::s_write);
	assign o_wr_data  = vram_pkg::pack_pixel(i_rd_rgb);	// Packed straight from the buffer

	assign o_line_complete = w_line_end;	// One cycle, after burst 45

endmodule

//--- design/line_buffer.sv
// Two line banks; a line may hold at most BUFFER_DEPTH pixels or the pointer wraps
// Read port always looks at the bank not being written
`timescale 1ns/1ns

module line_buffer
(
	input  logic                i_clk_100_bus,
	input  logic                i_sys_rst,
	input  logic                i_line_start,	// One-cycle strobe, swaps banks
	input  logic                i_pix_valid,
	input  vram_pkg::t_rgb      i_pix_rgb,
	input  logic                i_rd_en,
	input  vram_pkg::t_buf_addr i_rd_idx,
	output vram_pkg::t_rgb      o_rd_rgb		// Valid one cycle after i_rd_idx
);

	////////////////////
	// Storage
	////////////////////

	// Bank 0 and bank 1
	vram_pkg::t_rgb mem_bank_0 [vram_pkg::BUFFER_DEPTH];
	vram_pkg::t_rgb mem_bank_1 [vram_pkg::BUFFER_DEPTH];

	logic                r_wr_bank;		// Bank being filled
	vram_pkg::t_buf_addr r_wr_ptr;		// Next write slot
	vram_pkg::t_rgb      r_rd_rgb;

	logic w_wr_en;

	// Pixels on the strobe cycle itself are dropped
	assign w_wr_en = i_pix_valid && !i_line_start;

	////////////////////
	// Write side
	////////////////////

	// Bank flag flips on every line start
	always_ff @(posedge i_clk_100_bus or posedge i_sys_rst)
	begin
		if (i_sys_rst)
		begin
			r_wr_bank <= 1'b0;	// Bank 0 fills first
		end
		else if (i_line_start)
		begin
			r_wr_bank <= !r_wr_bank;
		end
	end

	// Write pointer
	always_ff @(posedge i_clk_100_bus or posedge i_sys_rst)
	begin
		if (i_sys_rst)
		begin
			r_wr_ptr <= '0;
		end
		else if (i_line_start)
		begin
			r_wr_ptr <= '0;	// Fresh line in the new bank
		end
		else if (w_wr_en)
		begin
			r_wr_ptr <= r_wr_ptr + 1'b1;
		end
	end

	// Pixel write into the fill bank
	always_ff @(posedge i_clk_100_bus)
	begin
		if (w_wr_en && !r_wr_bank)
		begin
			mem_bank_0[r_wr_ptr] <= i_pix_rgb;
		end
		if (w_wr_en && r_wr_bank)
		begin
			mem_bank_1[r_wr_ptr] <= i_pix_rgb;
		end
	end

	////////////////////
	// Read side
	////////////////////

	// Registered read from the idle bank
	// Holds its value while i_rd_en is low so a stalled beat keeps its word
	always_ff @(posedge i_clk_100_bus)
	begin
		if (i_rd_en)
		begin
			if (r_wr_bank)
			begin
				r_rd_rgb <= mem_bank_0[i_rd_idx];
			end
			else
			begin
				r_rd_rgb <= mem_bank_1[i_rd_idx];
			end
		end
	end

	assign o_rd_rgb = r_rd_rgb;

endmodule

//--- design/line_capture.sv
// First line start only opens capture; no line is ready until the second start
// Source must not strobe again before the writer finishes the line
`timescale 1ns/1ns

module line_capture
(
	input  logic                i_clk_100_bus,
	input  logic                i_sys_rst,
	input  logic                i_line_start,
	input  vram_pkg::t_line_num i_line_num,		// Valid with i_line_start
	input  logic                i_line_complete,	// Writer finished the read bank
	output logic                o_line_ready,
	output vram_pkg::t_line_num o_line_num		// Line sitting in the read bank
);

	logic                r_have_line;	// Some line is being captured
	vram_pkg::t_line_num r_cur_line;	// Line going into the write bank
	vram_pkg::t_line_num r_done_line;	// Line now on the read side
	logic                r_line_ready;

	////////////////////
	// Line tracking
	////////////////////

	// On each start the line in capture moves to the read side
	always_ff @(posedge i_clk_100_bus or posedge i_sys_rst)
	begin
		if (i_sys_rst)
		begin
			r_have_line <= 1'b0;
			r_cur_line  <= '0;
			r_done_line <= '0;
		end
		else if (i_line_start)
		begin
			r_have_line <= 1'b1;
			r_cur_line  <= i_line_num;
			// Nothing captured yet, use the strobe's number
			if (r_have_line)
			begin
				r_done_line <= r_cur_line;
			end
			else
			begin
				r_done_line <= i_line_num;
			end
		end
	end

	////////////////////
	// Ready flag
	////////////////////

	// Set when a full bank swaps over, cleared by the writer
	always_ff @(posedge i_clk_100_bus or posedge i_sys_rst)
	begin
		if (i_sys_rst)
		begin
			r_line_ready <= 1'b0;
		end
		else if (i_line_start && r_have_line)
		begin
			r_line_ready <= 1'b1;	// Start wins over a same-cycle complete
		end
		else if (i_line_complete)
		begin
			r_line_ready <= 1'b0;
		end
	end

	assign o_line_ready = r_line_ready;
	assign o_line_num   = r_done_line;

endmodule

//--- design/video_to_ram.sv
// RGB line grabber to memory, single clock domain
// Source cannot be stalled; it must wait for o_line_done before the next line start
`timescale 1ns/1ns

module video_to_ram
(
	input  logic                i_clk_100_bus,
	input  logic                i_sys_rst,
	// Video in
	input  logic                i_line_start,
	input  vram_pkg::t_line_num i_line_num,
	input  logic                i_pix_valid,
	input  vram_pkg::t_rgb      i_pix_rgb,
	// Memory
	input  logic                i_mem_init_done,
	input  logic                i_addr_ack,
	input  logic                i_wr_ready,
	output logic                o_req,
	output vram_pkg::t_mem_addr o_addr,
	output logic                o_wr_valid,
	output vram_pkg::t_mem_word o_wr_data,
	output logic                o_line_done
);

	logic                line_ready;
	logic                line_complete;
	vram_pkg::t_line_num done_line_num;	// Line held in the read bank
	logic                rd_en;
	vram_pkg::t_buf_addr rd_idx;
	vram_pkg::t_rgb      rd_rgb;

	assign o_line_done = line_complete;

	////////////////////
	// Capture side
	////////////////////

	line_buffer u_line_buffer
	(
		.i_clk_100_bus (i_clk_100_bus),
		.i_sys_rst     (i_sys_rst),
		.i_line_start  (i_line_start),
		.i_pix_valid   (i_pix_valid),
		.i_pix_rgb     (i_pix_rgb),
		.i_rd_en       (rd_en),
		.i_rd_idx      (rd_idx),
		.o_rd_rgb      (rd_rgb)
	);

	line_capture u_line_capture
	(
		.i_clk_100_bus   (i_clk_100_bus),
		.i_sys_rst       (i_sys_rst),
		.i_line_start    (i_line_start),
		.i_line_num      (i_line_num),
		.i_line_complete (line_complete),
		.o_line_ready    (line_ready),
		.o_line_num      (done_line_num)
	);

	////////////////////
	// Memory side
	////////////////////

	burst_writer u_burst_writer
	(
		.i_clk_100_bus   (i_clk_100_bus),
		.i_sys_rst       (i_sys_rst),
		.i_mem_init_done (i_mem_init_done),
		.i_line_ready    (line_ready),
		.i_line_num      (done_line_num),
		.o_rd_en         (rd_en),
		.o_rd_idx        (rd_idx),
		.i_rd_rgb        (rd_rgb),
		.o_req           (o_req),
		.o_addr          (o_addr),
		.i_addr_ack      (i_addr_ack),
		.o_wr_valid      (o_wr_valid),
		.o_wr_data       (o_wr_data),
		.i_wr_ready      (i_wr_ready),
		.o_line_complete (line_complete)
	);

endmodule

//--- design/vram_pkg.sv
// Line, burst and address constants for the 720 x 480 grabber
// Burst length is fixed, so the memory must assume 16-word bursts
package vram_pkg;

	////////////////////
	// Line geometry
	////////////////////

	localparam int unsigned PIXELS_PER_LINE = 720;	// Pixels written per line
	localparam int unsigned LINE_OFFSET     = 10;	// First pixel read, aligns the frame
	localparam int unsigned BUFFER_DEPTH    = 1024;	// Entries in each bank
	localparam int unsigned BUF_ADDR_BITS   = $clog2(BUFFER_DEPTH);

	localparam int unsigned LINES_PER_FRAME = 480;
	localparam int unsigned LINE_NUM_BITS   = $clog2(LINES_PER_FRAME);

	////////////////////
	// Bursts
	////////////////////

	localparam int unsigned BURST_LEN       = 16;	// Words per burst
	localparam int unsigned BYTES_PER_BURST = BURST_LEN * 4;
	localparam int unsigned BURSTS_PER_LINE = PIXELS_PER_LINE / BURST_LEN;	// 45
	localparam int unsigned BURST_CNT_BITS  = $clog2(BURSTS_PER_LINE + 1);	// Counts to 45
	localparam int unsigned BEAT_CNT_BITS   = $clog2(BURST_LEN);

	////////////////////
	// Memory map
	////////////////////

	localparam logic [31:0] VIDEO_RAM_BASE = 32'h0000_0000;
	localparam int unsigned BYTES_PER_LINE = 4096;	// Line pitch, one 4 KB page

	// Pixel as it arrives from the source
	typedef struct packed
	{
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} t_rgb;

	typedef logic [BUF_ADDR_BITS-1:0]  t_buf_addr;
	typedef logic [LINE_NUM_BITS-1:0]  t_line_num;
	typedef logic [31:0]               t_mem_addr;	// Byte address
	typedef logic [31:0]               t_mem_word;	// One packed pixel
	typedef logic [BURST_CNT_BITS-1:0] t_burst_cnt;
	typedef logic [BEAT_CNT_BITS-1:0]  t_beat_cnt;

	// Memory writer FSM
	typedef enum logic [2:0]
	{
		s_init,			// Waiting on memory init
		s_start_line,	// Waiting on a full line
		s_request,		// Address phase
		s_write,		// Data beats
		s_complete		// Burst done, step address
	} t_wr_state;

	// Word layout: zero byte, then 6 bits of R, G, B each padded with two zeros
	function automatic t_mem_word pack_pixel(input t_rgb pix);
		return {8'h00, pix.red[7:2], 2'b00, pix.green[7:2], 2'b00,
			pix.blue[7:2], 2'b00};
	endfunction

endpackage

//--- dv/tb_video_to_ram.sv
// Four random lines plus a flush line; memory acks after 0..3 cycles, ready stalls at random
// No new line start before o_line_done of the line two strobes back
`timescale 1ns/1ns

module tb_video_to_ram;

	logic                i_clk_100_bus;
	logic                i_sys_rst;
	logic                i_line_start;
	vram_pkg::t_line_num i_line_num;
	logic                i_pix_valid;
	vram_pkg::t_rgb      i_pix_rgb;
	logic                i_mem_init_done;
	logic                i_addr_ack;
	logic                i_wr_ready;
	logic                o_req;
	vram_pkg::t_mem_addr o_addr;
	logic                o_wr_valid;
	vram_pkg::t_mem_word o_wr_data;
	logic                o_line_done;

	vram_pkg::t_line_num line_q[$];	// Lines waiting for the writer, oldest first
	logic [31:0]         seed_q[$];	// Pixel seed per queued line
	int unsigned         burst_idx;	// Acks seen in the current line
	int unsigned         beat_idx;	// Beats seen in the current line
	int unsigned         lines_done;
	int unsigned         strobes_seen;
	logic                init_seen;
	logic                write_allowed;
	int unsigned         ack_wait;	// Cycles left before the next ack
	int unsigned         mismatch_cnt;
	int unsigned         other_cnt;
	vram_pkg::t_mem_addr exp_addr;
	vram_pkg::t_mem_word exp_word;

	video_to_ram u_video_to_ram
	(
		.i_clk_100_bus   (i_clk_100_bus),
		.i_sys_rst       (i_sys_rst),
		.i_line_start    (i_line_start),
		.i_line_num      (i_line_num),
		.i_pix_valid     (i_pix_valid),
		.i_pix_rgb       (i_pix_rgb),
		.i_mem_init_done (i_mem_init_done),
		.i_addr_ack      (i_addr_ack),
		.i_wr_ready      (i_wr_ready),
		.o_req           (o_req),
		.o_addr          (o_addr),
		.o_wr_valid      (o_wr_valid),
		.o_wr_data       (o_wr_data),
		.o_line_done     (o_line_done)
	);

	bind video_to_ram video_to_ram_sva u_video_to_ram_sva
	(
		.i_clk_100_bus (i_clk_100_bus),
		.i_sys_rst     (i_sys_rst),
		.i_req         (o_req),
		.i_addr        (o_addr),
		.i_addr_ack    (i_addr_ack),
		.i_wr_valid    (o_wr_valid),
		.i_wr_data     (o_wr_data),
		.i_wr_ready    (i_wr_ready),
		.i_line_done   (o_line_done)
	);

	initial
	begin
		i_clk_100_bus = 1'b0;
		forever
		begin
			#5 i_clk_100_bus = ~i_clk_100_bus;	// 100 MHz
		end
	end

	// Hash of line seed, line number and pixel index
	function automatic vram_pkg::t_rgb pixel_value(input logic [31:0] seed,
		input vram_pkg::t_line_num line_num, input int unsigned idx);
		logic [31:0] h;
		h = seed ^ {line_num, 23'd0} ^ (idx * 32'h9e37_79b1);
		h = h ^ (h >> 13);
		h = h * 32'h2c1b_3c6d;
		h = h ^ (h >> 16);
		return vram_pkg::t_rgb'(h[23:0]);
	endfunction

	// Zero top byte and low two bits of each colour dropped
	function automatic vram_pkg::t_mem_word expected_word(input vram_pkg::t_rgb pix);
		logic [23:0] raw;
		raw = pix;
		return {8'h00, raw & 24'hfc_fcfc};
	endfunction

	// Strobe, then one pixel per cycle with no gaps
	task automatic send_line(input vram_pkg::t_line_num line_num, input logic [31:0] seed);
		int unsigned idx;
		@(posedge i_clk_100_bus);
		i_line_start <= 1'b1;
		i_line_num   <= line_num;
		for (idx = 0; idx < vram_pkg::LINE_OFFSET + vram_pkg::PIXELS_PER_LINE; idx++)
		begin
			@(posedge i_clk_100_bus);
			i_line_start <= 1'b0;
			i_pix_valid  <= 1'b1;
			i_pix_rgb    <= pixel_value(seed, line_num, idx);
		end
		@(posedge i_clk_100_bus);
		i_pix_valid <= 1'b0;
	endtask

	////////////////////
	// Memory slave
	////////////////////

	always @(posedge i_clk_100_bus)
	begin
		if (i_sys_rst)
		begin
			i_addr_ack <= 1'b0;
			i_wr_ready <= 1'b0;
			ack_wait   <= 0;
		end
		else
		begin
			i_wr_ready <= ($urandom_range(3) != 0);	// Stall about one cycle in four
			if (o_req && !i_addr_ack)
			begin
				if (ack_wait == 0)
				begin
					i_addr_ack <= 1'b1;
					ack_wait   <= $urandom_range(3);	// Delay for the next burst
				end
				else
				begin
					ack_wait <= ack_wait - 1;
				end
			end
			else
			begin
				i_addr_ack <= 1'b0;	// One-cycle ack
			end
		end
	end

	// Line ready only after the second strobe, init comes later still
	initial
	begin
		wait (strobes_seen == 2);
		repeat (25) @(posedge i_clk_100_bus);
		i_mem_init_done <= 1'b1;
	end

	////////////////////
	// Checks
	////////////////////

	assign write_allowed = init_seen && (strobes_seen >= 2);

	a_idle_until_line: assert property (@(posedge i_clk_100_bus) disable iff (i_sys_rst)
		!write_allowed |-> !o_req && !o_wr_valid && !o_line_done)
		else
		begin
			other_cnt++;
			$display("%0t: bus active before memory init and a full line", $time);
		end

	always @(posedge i_clk_100_bus)
	begin
		if (!i_sys_rst)
		begin
			strobes_seen = strobes_seen + i_line_start;
			init_seen    = init_seen | i_mem_init_done;
			if ((o_req && i_addr_ack) || (o_wr_valid && i_wr_ready) || o_line_done)
			begin
				assert (line_q.size() != 0)
				else
				begin
					other_cnt++;
					$display("%0t: bus traffic with no captured line", $time);
				end
			end
			if (o_req && i_addr_ack && line_q.size() != 0)
			begin
				exp_addr = vram_pkg::VIDEO_RAM_BASE + line_q[0] * vram_pkg::BYTES_PER_LINE +
					burst_idx * vram_pkg::BYTES_PER_BURST;
				assert (o_addr == exp_addr)
				else
				begin
					mismatch_cnt++;
					$display("MISMATCH %0t o_addr expected %h got %h", $time, exp_addr, o_addr);
				end
				burst_idx++;
			end
			if (o_wr_valid && i_wr_ready && line_q.size() != 0)
			begin
				exp_word = expected_word(pixel_value(seed_q[0], line_q[0],
					vram_pkg::LINE_OFFSET + beat_idx));
				assert (o_wr_data == exp_word)
				else
				begin
					mismatch_cnt++;
					$display("MISMATCH %0t o_wr_data expected %h got %h", $time, exp_word,
						o_wr_data);
				end
				beat_idx++;
			end
			if (o_line_done && line_q.size() != 0)
			begin
				assert (burst_idx == vram_pkg::BURSTS_PER_LINE &&
					beat_idx == vram_pkg::PIXELS_PER_LINE)
				else
				begin
					other_cnt++;
					$display("%0t: o_line_done after %0d bursts and %0d beats", $time,
						burst_idx, beat_idx);
				end
				void'(line_q.pop_front());
				void'(seed_q.pop_front());
				burst_idx  = 0;
				beat_idx   = 0;
				lines_done = lines_done + 1;
			end
		end
	end

	////////////////////
	// Main sequence
	////////////////////

	initial
	begin
		vram_pkg::t_line_num line_num;
		logic [31:0]         seed;
		int unsigned         n;
		int unsigned         sva_cnt;
		void'($urandom(32'h6b7f96ae));
		i_sys_rst       = 1'b1;
		i_line_start    = 1'b0;
		i_line_num      = '0;
		i_pix_valid     = 1'b0;
		i_pix_rgb       = '0;
		i_mem_init_done = 1'b0;
		i_addr_ack      = 1'b0;
		i_wr_ready      = 1'b0;
		burst_idx       = 0;
		beat_idx        = 0;
		lines_done      = 0;
		strobes_seen    = 0;
		init_seen       = 1'b0;
		mismatch_cnt    = 0;
		other_cnt       = 0;
		repeat (4) @(posedge i_clk_100_bus);
		i_sys_rst <= 1'b0;
		// Fifth start only flushes the fourth line
		for (n = 0; n < 5; n++)
		begin
			wait (lines_done + 1 >= n);	// Previous line fully written
			line_num = vram_pkg::t_line_num'($urandom_range(vram_pkg::LINES_PER_FRAME - 1));
			seed     = $urandom;
			if (n < 4)
			begin
				line_q.push_back(line_num);
				seed_q.push_back(seed);
			end
			send_line(line_num, seed);
		end
		wait (lines_done == 4);
		repeat (20) @(posedge i_clk_100_bus);	// Let late assertions fire
		sva_cnt = u_video_to_ram.u_video_to_ram_sva.fail_cnt;
		$display("Errors: %0d mismatches, %0d protocol, %0d other", mismatch_cnt, sva_cnt,
			other_cnt);
		if (mismatch_cnt + sva_cnt + other_cnt == 0)
		begin
			$display("Finished with no errors");
		end
		else
		begin
			$display("Finished with errors");
		end
		$finish;
	end

	// Four lines plus flush with up to four cycles per beat
	initial
	begin
		int unsigned wd_cycles;
		wd_cycles = 5 * (vram_pkg::LINE_OFFSET + vram_pkg::PIXELS_PER_LINE +
			vram_pkg::BURSTS_PER_LINE * vram_pkg::BURST_LEN * 4);
		repeat (wd_cycles) @(posedge i_clk_100_bus);
		$display("%0t: watchdog expired with %0d of 4 lines written", $time, lines_done);
		$display("Finished with errors");
		$finish;
	end

endmodule

//--- dv/video_to_ram_sva.sv
// Burst bus protocol checks, bound into video_to_ram
// The bus carries no burst length, so BURST_LEN beats are expected after every ack
`timescale 1ns/1ns

module video_to_ram_sva
(
	input logic                i_clk_100_bus,
	input logic                i_sys_rst,
	input logic                i_req,
	input vram_pkg::t_mem_addr i_addr,
	input logic                i_addr_ack,
	input logic                i_wr_valid,
	input vram_pkg::t_mem_word i_wr_data,
	input logic                i_wr_ready,
	input logic                i_line_done
);

	int unsigned r_beat_cnt;	// Beats since the last ack
	int unsigned fail_cnt = 0;	// Failed assertions, summed by the testbench

	// Starts full so the first ack sees a finished burst
	always_ff @(posedge i_clk_100_bus or posedge i_sys_rst)
	begin
		if (i_sys_rst)
		begin
			r_beat_cnt <= vram_pkg::BURST_LEN;
		end
		else if (i_req && i_addr_ack)
		begin
			r_beat_cnt <= 0;
		end
		else if (i_wr_valid && i_wr_ready)
		begin
			r_beat_cnt <= r_beat_cnt + 1;
		end
	end

	////////////////////
	// Address phase
	////////////////////

	a_req_hold: assert property (@(posedge i_clk_100_bus) disable iff (i_sys_rst)
		i_req && !i_addr_ack |=> i_req && $stable(i_addr))
		else
		begin
			fail_cnt++;
			$error("o_req dropped or o_addr moved before i_addr_ack");
		end

	// First beat offered the cycle after the ack
	a_ack_to_beat: assert property (@(posedge i_clk_100_bus) disable iff (i_sys_rst)
		i_req && i_addr_ack |=> i_wr_valid)
		else
		begin
			fail_cnt++;
			$error("No data beat offered one cycle after i_addr_ack");
		end

	////////////////////
	// Data phase
	////////////////////

	a_data_hold: assert property (@(posedge i_clk_100_bus) disable iff (i_sys_rst)
		i_wr_valid && !i_wr_ready |=> i_wr_valid && $stable(i_wr_data))
		else
		begin
			fail_cnt++;
			$error("o_wr_valid or o_wr_data changed during a stall");
		end

	a_no_extra_beat: assert property (@(posedge i_clk_100_bus) disable iff (i_sys_rst)
		i_wr_valid |-> r_beat_cnt < vram_pkg::BURST_LEN)
		else
		begin
			fail_cnt++;
			$error("More than BURST_LEN beats after one ack");
		end

	// Previous burst must be complete before the next ack or the line end
	a_burst_full: assert property (@(posedge i_clk_100_bus) disable iff (i_sys_rst)
		(i_req && i_addr_ack) || i_line_done |-> r_beat_cnt == vram_pkg::BURST_LEN)
		else
		begin
			fail_cnt++;
			$error("Burst ended with fewer than BURST_LEN beats");
		end

endmodule

//--- vlog.f
design/vram_pkg.sv
design/line_buffer.sv
design/line_capture.sv
design/burst_writer.sv
design/video_to_ram.sv
dv/video_to_ram_sva.sv
dv/tb_video_to_ram.sv
